/* logic/rx_pkt_pkg.sv */
package rx_pkt_pkg;

    // Channel geometry
    localparam int NUM_CHAN = 4;
    localparam int CHAN_W = 2;

    localparam int FIFO_DEPTH = 512;
    localparam int USEDW_W = 10;  // One bit more than the address so full is visible

    // Packet layout toward the host
    localparam int PKT_WORDS = 256;
    localparam int MAX_PAYLOAD_WORDS = 252;
    localparam logic [15:0] PAD_WORD = 16'hdead;

    typedef enum logic [2:0] {
        IDLE,
        HEADER1,
        HEADER2,
        TS_LOW,
        TS_HIGH,
        FORWARD
    } builder_state_e;

    // Time halves are 16 bits each and read back zero-extended
    typedef enum logic [1:0] {
        CFG_CHAN_LAST,
        CFG_ENABLE,
        CFG_TIME_LO,
        CFG_TIME_HI
    } cfg_addr_e;

endpackage

/* logic/rx_chan_fifo.sv */
module rx_chan_fifo (
    input  logic                           rxclk,
    input  logic                           reset,
    input  logic                           wr_en,
    input  logic                           rx_enable,
    input  logic [15:0]                    wr_data,
    input  logic                           rdreq,
    input  logic                           ovr_clr,
    output logic [15:0]                    rd_data,
    output logic                           empty,
    output logic [rx_pkt_pkg::USEDW_W-1:0] usedw,
    output logic                           overrun
);
    import rx_pkt_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    logic [15:0]       mem [FIFO_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic              full;
    logic              strobe;
    logic              do_wr;
    logic              do_rd;
    logic              drop;

    assign strobe = wr_en && rx_enable;  // Strobes are ignored while reception is off
    assign full   = (usedw == USEDW_W'(FIFO_DEPTH));
    assign empty  = (usedw == '0);
    assign do_wr  = strobe && !full;
    assign do_rd  = rdreq && !empty;
    assign drop   = strobe && full;

    always_ff @(posedge rxclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_rd) begin
            rd_data <= mem[rd_ptr];  // Data valid the cycle after rdreq
        end
    end

    always_ff @(posedge rxclk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            usedw   <= '0;
            overrun <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            usedw <= usedw + USEDW_W'(do_wr) - USEDW_W'(do_rd);

            // A fresh drop wins over a clear in the same cycle
            if (drop) begin
                overrun <= 1'b1;
            end else if (ovr_clr) begin
                overrun <= 1'b0;
            end
        end
    end

endmodule

/* logic/rx_cfg_regs.sv */
module rx_cfg_regs (
    input  logic                          rxclk,
    input  logic                          reset,
    input  logic                          cfg_wr,
    input  rx_pkt_pkg::cfg_addr_e         cfg_addr,
    input  logic [31:0]                   cfg_wdata,
    output logic [31:0]                   cfg_rdata,
    output logic [rx_pkt_pkg::CHAN_W-1:0] chan_last,
    output logic                          rx_enable,
    output logic [31:0]                   adctime
);
    import rx_pkt_pkg::*;

    always_ff @(posedge rxclk) begin
        if (reset) begin
            chan_last <= '0;
            rx_enable <= 1'b0;
            adctime   <= '0;
        end else begin
            adctime <= adctime + 32'd1;  // Free-running sample clock count
            if (cfg_wr) begin
                case (cfg_addr)
                    CFG_CHAN_LAST: chan_last <= cfg_wdata[CHAN_W-1:0];
                    CFG_ENABLE:    rx_enable <= cfg_wdata[0];
                    // A half-word load replaces the increment for that cycle
                    CFG_TIME_LO:   adctime <= {adctime[31:16], cfg_wdata[15:0]};
                    CFG_TIME_HI:   adctime <= {cfg_wdata[15:0], adctime[15:0]};
                    default:       ;
                endcase
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            CFG_CHAN_LAST: cfg_rdata = 32'(chan_last);
            CFG_ENABLE:    cfg_rdata = {31'd0, rx_enable};
            CFG_TIME_LO:   cfg_rdata = {16'd0, adctime[15:0]};
            CFG_TIME_HI:   cfg_rdata = {16'd0, adctime[31:16]};
            default:       cfg_rdata = '0;
        endcase
    end

endmodule

/* logic/rx_packet_builder.sv */
module rx_packet_builder (
    input  logic                                             rxclk,
    input  logic                                             reset,
    input  logic                                             have_space,
    input  logic [rx_pkt_pkg::CHAN_W-1:0]                    chan_last,
    input  logic [31:0]                                      adctime,
    input  logic [rx_pkt_pkg::NUM_CHAN-1:0]                  chan_empty,
    input  logic [rx_pkt_pkg::NUM_CHAN-1:0][rx_pkt_pkg::USEDW_W-1:0] chan_usedw,
    input  logic [rx_pkt_pkg::NUM_CHAN-1:0]                  chan_overrun,
    input  logic [15:0]                                      chan_fifodata,
    input  logic [rx_pkt_pkg::NUM_CHAN-1:0][31:0]            rssi_in,
    output logic [rx_pkt_pkg::CHAN_W-1:0]                    rd_select,
    output logic                                             chan_rdreq,
    output logic                                             ovr_clr,
    output logic                                             wr,
    output logic [15:0]                                      fifodata
);
    import rx_pkt_pkg::*;

    localparam int WORD_W = $clog2(PKT_WORDS);
    localparam int HDR_WORDS = PKT_WORDS - MAX_PAYLOAD_WORDS;

    // Header word 0
    localparam int LEN_LSB = 0;
    localparam int LEN_MSB = 8;
    localparam int TAG_LSB = 9;
    localparam int TAG_MSB = 12;
    localparam int MBZ_LSB = 13;
    localparam int MBZ_MSB = 15;

    // Header word 1
    localparam int CHAN_LSB = 0;
    localparam int CHAN_MSB = 4;
    localparam int RSSI_LSB = 5;
    localparam int RSSI_MSB = 10;
    localparam int BURST_LSB = 11;
    localparam int BURST_MSB = 12;
    localparam int DROPPED_BIT = 13;
    localparam int UNDERRUN_BIT = 14;
    localparam int OVERRUN_BIT = 15;

    builder_state_e      state;
    logic [CHAN_W-1:0]   check_next;
    logic [WORD_W-1:0]   word_cnt;    // Index of the packet word being registered
    logic [WORD_W-1:0]   req_cnt;
    logic [WORD_W-1:0]   payload_n;
    logic [WORD_W-1:0]   n_next;
    logic [WORD_W-1:0]   pay_idx;
    logic [USEDW_W-1:0]  sel_usedw;
    logic [31:0]         sel_rssi;
    logic                ovr_seen;
    logic [15:0]         ts_hi;
    logic [15:0]         hdr0;
    logic [15:0]         hdr1;

    assign sel_usedw = chan_usedw[rd_select];
    assign sel_rssi  = rssi_in[rd_select];
    assign n_next    = (sel_usedw > USEDW_W'(MAX_PAYLOAD_WORDS)) ?
                       WORD_W'(MAX_PAYLOAD_WORDS) : sel_usedw[WORD_W-1:0];
    assign pay_idx   = word_cnt - WORD_W'(HDR_WORDS);

    // One request per payload word, issued a cycle ahead of its use
    assign chan_rdreq = ((state == TS_HIGH) || (state == FORWARD)) && (req_cnt < payload_n);
    assign ovr_clr    = (state == HEADER1);

    always_comb begin
        hdr0 = '0;
        hdr0[LEN_MSB:LEN_LSB] = {n_next, 1'b0};  // Length in bytes
        hdr0[TAG_MSB:TAG_LSB] = '0;
        hdr0[MBZ_MSB:MBZ_LSB] = '0;

        hdr1 = '0;
        hdr1[CHAN_MSB:CHAN_LSB] = 5'(rd_select);
        hdr1[RSSI_MSB:RSSI_LSB] = sel_rssi[5:0];
        hdr1[BURST_MSB:BURST_LSB] = '0;
        hdr1[DROPPED_BIT] = 1'b0;
        hdr1[UNDERRUN_BIT] = 1'b0;
        hdr1[OVERRUN_BIT] = ovr_seen;
    end

    always_ff @(posedge rxclk) begin
        if (reset) begin
            state      <= IDLE;
            wr         <= 1'b0;
            rd_select  <= '0;
            check_next <= '0;
            word_cnt   <= '0;
            req_cnt    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    wr <= 1'b0;  // The final packet word is on the bus during this cycle
                    if (have_space) begin
                        if (!chan_empty[check_next]) begin
                            rd_select <= check_next;
                            state     <= HEADER1;
                        end
                        check_next <= (check_next == chan_last) ? '0 : check_next + 1'b1;
                    end
                end
                HEADER1: begin
                    wr    <= 1'b1;
                    state <= HEADER2;
                end
                HEADER2: state <= TS_LOW;
                TS_LOW:  state <= TS_HIGH;
                TS_HIGH: state <= FORWARD;
                FORWARD: begin
                    if (word_cnt == WORD_W'(PKT_WORDS - 1)) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            if (state == IDLE) begin
                word_cnt <= '0;
                req_cnt  <= '0;
            end else begin
                word_cnt <= word_cnt + 1'b1;
                if (chan_rdreq) begin
                    req_cnt <= req_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge rxclk) begin
        case (state)
            HEADER1: begin
                fifodata  <= hdr0;
                payload_n <= n_next;
                ovr_seen  <= chan_overrun[rd_select];  // Cleared in the FIFO at this edge
            end
            HEADER2: fifodata <= hdr1;
            TS_LOW: begin
                // Both halves come from the same count
                fifodata <= adctime[15:0];
                ts_hi    <= adctime[31:16];
            end
            TS_HIGH: fifodata <= ts_hi;
            FORWARD: fifodata <= (pay_idx < payload_n) ? chan_fifodata : PAD_WORD;
            default: ;
        endcase
    end

endmodule

/* logic/rx_packet_top.sv */
module rx_packet_top (
    input  logic                                         rxclk,
    input  logic                                         reset,
    input  logic [rx_pkt_pkg::NUM_CHAN-1:0]              sample_strobe,
    input  logic [rx_pkt_pkg::NUM_CHAN-1:0][15:0]        sample_data,
    input  logic [rx_pkt_pkg::NUM_CHAN-1:0][31:0]        rssi_in,
    input  logic                                         have_space,
    input  logic                                         cfg_wr,
    input  rx_pkt_pkg::cfg_addr_e                        cfg_addr,
    input  logic [31:0]                                  cfg_wdata,
    output logic                                         wr,
    output logic [15:0]                                  fifodata,
    output logic [31:0]                                  cfg_rdata
);
    import rx_pkt_pkg::*;

    logic [CHAN_W-1:0]                chan_last;
    logic                             rx_enable;
    logic [31:0]                      adctime;
    logic [NUM_CHAN-1:0]              chan_empty;
    logic [NUM_CHAN-1:0][USEDW_W-1:0] chan_usedw;
    logic [NUM_CHAN-1:0]              chan_overrun;
    logic [NUM_CHAN-1:0][15:0]        fifo_rd_data;
    logic [NUM_CHAN-1:0]              fifo_rdreq;
    logic [NUM_CHAN-1:0]              fifo_ovr_clr;
    logic [15:0]                      chan_fifodata;
    logic [CHAN_W-1:0]                rd_select;
    logic                             chan_rdreq;
    logic                             ovr_clr;

    assign chan_fifodata = fifo_rd_data[rd_select];

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        // Only the FIFO being served sees the read and clear strobes
        assign fifo_rdreq[i]   = chan_rdreq && (rd_select == CHAN_W'(i));
        assign fifo_ovr_clr[i] = ovr_clr && (rd_select == CHAN_W'(i));

        rx_chan_fifo u_fifo (
            .rxclk     (rxclk),
            .reset     (reset),
            .wr_en     (sample_strobe[i]),
            .rx_enable (rx_enable),
            .wr_data   (sample_data[i]),
            .rdreq     (fifo_rdreq[i]),
            .ovr_clr   (fifo_ovr_clr[i]),
            .rd_data   (fifo_rd_data[i]),
            .empty     (chan_empty[i]),
            .usedw     (chan_usedw[i]),
            .overrun   (chan_overrun[i])
        );
    end

    rx_cfg_regs u_cfg_regs (
        .rxclk     (rxclk),
        .reset     (reset),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .chan_last (chan_last),
        .rx_enable (rx_enable),
        .adctime   (adctime)
    );

    rx_packet_builder u_builder (
        .rxclk         (rxclk),
        .reset         (reset),
        .have_space    (have_space),
        .chan_last     (chan_last),
        .adctime       (adctime),
        .chan_empty    (chan_empty),
        .chan_usedw    (chan_usedw),
        .chan_overrun  (chan_overrun),
        .chan_fifodata (chan_fifodata),
        .rssi_in       (rssi_in),
        .rd_select     (rd_select),
        .chan_rdreq    (chan_rdreq),
        .ovr_clr       (ovr_clr),
        .wr            (wr),
        .fifodata      (fifodata)
    );

endmodule

/* verif/rx_packet_chk.sv */
module rx_packet_chk (
    input logic                            rxclk,
    input logic                            reset,
    input logic                            wr,
    input logic [15:0]                     fifodata,
    input rx_pkt_pkg::builder_state_e      state,
    input logic                            chan_rdreq,
    input logic [rx_pkt_pkg::NUM_CHAN-1:0] chan_empty,
    input logic [rx_pkt_pkg::CHAN_W-1:0]   rd_select
);
    import rx_pkt_pkg::*;

    int run_len;  // High cycles of the current host write burst

    always_ff @(posedge rxclk) begin
        if (reset || !wr) begin
            run_len <= 0;
        end else begin
            run_len <= run_len + 1;
        end
    end

    a_burst_len: assert property (@(posedge rxclk) disable iff (reset)
        $fell(wr) |-> run_len == PKT_WORDS)
        else $error("Host write burst ended after %0d cycles", run_len);

    a_burst_max: assert property (@(posedge rxclk) disable iff (reset)
        wr |-> run_len < PKT_WORDS)
        else $error("Host write burst runs past one packet");

    a_rdreq_empty: assert property (@(posedge rxclk) disable iff (reset)
        chan_rdreq |-> !chan_empty[rd_select])
        else $error("Read request to empty channel %0d", rd_select);

    // First word of a burst is header word 0
    a_hdr0_zero: assert property (@(posedge rxclk) disable iff (reset)
        $rose(wr) |-> (state == HEADER2) && (fifodata[15:13] == 3'b000))
        else $error("Header word 0 has reserved bits set: %h", fifodata);

    a_reset_wr: assert property (@(posedge rxclk) reset |=> !wr)
        else $error("Host write active right after reset");

endmodule

bind rx_packet_builder rx_packet_chk u_chk (
    .rxclk      (rxclk),
    .reset      (reset),
    .wr         (wr),
    .fifodata   (fifodata),
    .state      (state),
    .chan_rdreq (chan_rdreq),
    .chan_empty (chan_empty),
    .rd_select  (rd_select)
);

/* verif/rx_packet_tb.sv */
module rx_packet_tb;
    import rx_pkt_pkg::*;

    localparam int CAPTURE_TIMEOUT = 2000;
    localparam int QUIET_CYCLES = 600;
    localparam logic [15:0] FILL = 16'hdead;

    logic                      rxclk;
    logic                      reset;
    logic [NUM_CHAN-1:0]       sample_strobe;
    logic [NUM_CHAN-1:0][15:0] sample_data;
    logic [NUM_CHAN-1:0][31:0] rssi_in;
    logic                      have_space;
    logic                      cfg_wr;
    cfg_addr_e                 cfg_addr;
    logic [31:0]               cfg_wdata;
    logic                      wr;
    logic [15:0]               fifodata;
    logic [31:0]               cfg_rdata;

    logic [31:0] lcg_state = 32'h8e8c;
    logic [15:0] pkt [PKT_WORDS];
    logic [15:0] sent [NUM_CHAN][$];  // Samples each FIFO accepted, oldest first
    int          error_count = 0;
    int          check_count = 0;

    rx_packet_top u_rx_packet_top (.*);

    initial begin
        rxclk = 1'b0;
        forever #5 rxclk = ~rxclk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic note_failure(input string what);
        error_count++;
        $display("%s", what);
    endtask

    task automatic check_word(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Timestamps only have a lower bound since the start latency varies
    task automatic check_time(input string name, input logic [31:0] lower,
                              input logic [31:0] actual);
        check_count++;
        if ($isunknown(actual) || actual < lower) begin
            error_count++;
            $display("[ERROR] %s: expected at least %h, actual %h", name, lower, actual);
        end
    endtask

    task automatic check_cfg(input string name, input cfg_addr_e addr,
                             input logic [31:0] expected);
        @(posedge rxclk);
        #1;
        cfg_addr = addr;
        @(negedge rxclk);  // Readback is combinational
        check_count++;
        if (cfg_rdata !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, cfg_rdata);
        end
    endtask

    task automatic write_cfg(input cfg_addr_e addr, input logic [31:0] data);
        @(posedge rxclk);
        #1;
        cfg_wr = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(posedge rxclk);
        #1;
        cfg_wr = 1'b0;
    endtask

    task automatic set_space(input logic value);
        @(posedge rxclk);
        #1;
        have_space = value;
    endtask

    task automatic send_samples(input int chan, input int count, input bit record);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            @(posedge rxclk);
            #1;
            rnd = next_rand();
            sample_strobe[chan] = 1'b1;
            sample_data[chan] = rnd[31:16];
            if (record && sent[chan].size() < FIFO_DEPTH) begin
                sent[chan].push_back(rnd[31:16]);  // A full FIFO drops the sample
            end
        end
        @(posedge rxclk);
        #1;
        sample_strobe = '0;
    endtask

    task automatic restart(input logic [31:0] last, input logic enable);
        @(posedge rxclk);
        #1;
        reset = 1'b1;
        have_space = 1'b0;
        sample_strobe = '0;
        repeat (5) @(posedge rxclk);
        #1;
        reset = 1'b0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            sent[c].delete();
        end
        write_cfg(CFG_CHAN_LAST, last);
        write_cfg(CFG_ENABLE, {31'd0, enable});
    endtask

    task automatic capture_packet(input string name, output bit ok);
        logic prev;
        int   wait_cnt;
        ok = 1'b0;
        prev = wr;
        wait_cnt = 0;
        while (!(wr && !prev)) begin
            prev = wr;
            @(negedge rxclk);
            wait_cnt++;
            if (wait_cnt > CAPTURE_TIMEOUT) begin
                note_failure($sformatf("%s: no packet started within %0d cycles",
                                       name, CAPTURE_TIMEOUT));
                return;
            end
        end
        pkt[0] = fifodata;
        for (int idx = 1; idx < PKT_WORDS; idx++) begin
            @(negedge rxclk);
            if (!wr) begin
                note_failure($sformatf("%s: host write stopped after %0d words", name, idx));
                return;
            end
            pkt[idx] = fifodata;
        end
        ok = 1'b1;
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge rxclk);
            if (wr) begin
                note_failure($sformatf("%s: unexpected host write after %0d cycles", name, i));
                return;
            end
        end
    endtask

    task automatic check_packet(input string name, input int chan, input int n,
                                input logic ovr);
        logic [15:0] expected;
        check_word({name, " header0"}, {7'd0, 9'(2 * n)}, pkt[0]);
        check_word({name, " header1"},
                   {ovr, 1'b0, 1'b0, 2'b00, rssi_in[chan][5:0], 5'(chan)}, pkt[1]);
        for (int i = 0; i < MAX_PAYLOAD_WORDS; i++) begin
            expected = FILL;
            if (i < n) begin
                expected = sent[chan].pop_front();
            end
            check_word($sformatf("%s payload %0d", name, i), expected, pkt[i + 4]);
        end
    endtask

    task automatic run_packets(input string name, input int chan, input int n,
                               input logic ovr);
        bit ok;
        capture_packet(name, ok);
        if (ok) begin
            check_packet(name, chan, n, ovr);
        end
    endtask

    initial begin
        reset = 1'b1;
        have_space = 1'b0;
        sample_strobe = '0;
        sample_data = '0;
        cfg_wr = 1'b0;
        cfg_addr = CFG_CHAN_LAST;
        cfg_wdata = '0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            rssi_in[c] = next_rand();
        end
        repeat (5) @(posedge rxclk);
        #1;
        reset = 1'b0;

        // Registers, and strobes ignored while reception is off
        restart(32'd3, 1'b0);
        write_cfg(CFG_TIME_HI, 32'h0000_00ab);
        check_cfg("regs_chan_last", CFG_CHAN_LAST, 32'd3);
        check_cfg("regs_time_hi", CFG_TIME_HI, 32'h0000_00ab);
        check_cfg("regs_disabled", CFG_ENABLE, 32'd0);
        set_space(1'b1);
        send_samples(0, 8, 1'b0);
        expect_quiet("regs_disabled", QUIET_CYCLES);
        write_cfg(CFG_ENABLE, 32'd1);
        check_cfg("regs_enable", CFG_ENABLE, 32'd1);

        restart(32'd3, 1'b1);
        send_samples(0, 10, 1'b1);
        set_space(1'b1);
        run_packets("short", 0, 10, 1'b0);

        restart(32'd3, 1'b1);
        send_samples(0, 300, 1'b1);
        set_space(1'b1);
        run_packets("long_first", 0, MAX_PAYLOAD_WORDS, 1'b0);
        run_packets("long_second", 0, 48, 1'b0);

        restart(32'd2, 1'b1);
        for (int c = 0; c < NUM_CHAN; c++) begin
            send_samples(c, 5, 1'b1);
        end
        set_space(1'b1);
        for (int c = 0; c < 3; c++) begin
            run_packets($sformatf("round_robin_ch%0d", c), c, 5, 1'b0);
        end
        expect_quiet("round_robin_ch3", QUIET_CYCLES);

        test_timestamp();

        restart(32'd3, 1'b1);
        send_samples(1, 520, 1'b1);
        set_space(1'b1);
        run_packets("overrun_first", 1, MAX_PAYLOAD_WORDS, 1'b1);
        run_packets("overrun_second", 1, MAX_PAYLOAD_WORDS, 1'b0);
        run_packets("overrun_rest", 1, 8, 1'b0);

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    task automatic test_timestamp();
        logic [31:0] ts_first;
        restart(32'd3, 1'b1);
        send_samples(2, 20, 1'b1);
        expect_quiet("ts_no_space", 100);
        write_cfg(CFG_TIME_LO, 32'h0000_0100);  // Low half first so no carry reaches the top
        write_cfg(CFG_TIME_HI, 32'h0000_1234);
        check_cfg("ts_load", CFG_TIME_HI, 32'h0000_1234);
        set_space(1'b1);
        run_packets("ts_first", 2, 20, 1'b0);
        ts_first = {pkt[3], pkt[2]};
        check_time("ts_first", 32'h1234_0100, ts_first);
        set_space(1'b0);
        send_samples(2, 20, 1'b1);
        set_space(1'b1);
        run_packets("ts_second", 2, 20, 1'b0);
        check_time("ts_second", ts_first + 32'd1, {pkt[3], pkt[2]});
    endtask

endmodule

/* compile.f */
logic/rx_pkt_pkg.sv
logic/rx_chan_fifo.sv
logic/rx_cfg_regs.sv
logic/rx_packet_builder.sv
logic/rx_packet_top.sv
verif/rx_packet_chk.sv
verif/rx_packet_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rx_packet_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)
